//--- console_params.svh
`ifndef CONSOLE_PARAMS_SVH
`define CONSOLE_PARAMS_SVH

// ------------------------------
// data widths
// ------------------------------
`define CON_BYTE_W      8       // one uart character
`define CON_SEED_W      32      // prng seed
`define CON_HEX_DIGITS  8       // seed dump length in characters

// ------------------------------
// ascii control characters
// ------------------------------
`define CON_ASCII_CR    8'h0D
`define CON_ASCII_LF    8'h0A
`define CON_ASCII_COLON 8'h3A

// value the seed takes out of reset
`define CON_SEED_RESET  32'h0000_0000

`endif

//--- console_pkg.sv
`default_nettype none

`include "console_params.svh"

package console_pkg;

    // ------------------------------
    // receive side
    // ------------------------------

    // one received character with its decode flags
    typedef struct packed {
        logic [`CON_BYTE_W-1:0] data;    // raw byte as received
        logic                   is_hex;  // 0-9, A-F, a-f
        logic                   is_cr;
        logic                   is_colon;
        logic                   is_cmd_load; // L or l
        logic                   is_cmd_read; // R or r
        logic [3:0]             nibble;  // value of a hex digit
    } rx_char_t;

    // ------------------------------
    // transmit side
    // ------------------------------

    // what the sequencer has to send for one request
    typedef enum logic [1:0] {
        REQ_ECHO = 2'd0,    // byte back, LF appended after CR
        REQ_DUMP = 2'd1     // seed as hex, then CR LF
    } req_kind_e;

    // single-cycle request from the parser
    typedef struct packed {
        logic                   valid;
        req_kind_e              kind;
        logic [`CON_BYTE_W-1:0] data;    // echo byte, unused for a dump
    } tx_req_t;

endpackage

`default_nettype wire

//--- uart_rx_capture.sv
`default_nettype none

`include "console_params.svh"

module uart_rx_capture (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_rx_rdy,
    input  wire logic [`CON_BYTE_W-1:0] i_rx_data,
    output logic                        o_char_strobe,
    output console_pkg::rx_char_t       o_char
);

    // upper-case forms, lower case folds onto them by clearing bit 5
    localparam logic [`CON_BYTE_W-1:0] CASE_MASK = 8'hDF;
    localparam logic [`CON_BYTE_W-1:0] CHR_L     = 8'h4C;
    localparam logic [`CON_BYTE_W-1:0] CHR_R     = 8'h52;

    logic [1:0]             rdy_hist;   // [0] newest sample
    logic [`CON_BYTE_W-1:0] data_q;
    logic [`CON_BYTE_W-1:0] data_up;    // case-folded copy
    logic                   is_digit;
    logic                   is_alpha;

    // ------------------------------
    // ready edge and byte capture
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy_hist      <= 2'b00;
            o_char_strobe <= 1'b0;
        end else begin
            rdy_hist      <= {rdy_hist[0], i_rx_rdy};
            o_char_strobe <= rdy_hist[0] & ~rdy_hist[1]; // one per high period
        end
    end

    // byte is only valid while ready is up, hold it afterwards
    always_ff @(posedge clk) begin
        if (i_rx_rdy) begin
            data_q <= i_rx_data;
        end
    end

    // ------------------------------
    // classification
    // ------------------------------
    assign data_up  = data_q & CASE_MASK;
    assign is_digit = (data_q >= 8'h30) && (data_q <= 8'h39);
    assign is_alpha = (data_up >= 8'h41) && (data_up <= 8'h46); // A-F and a-f

    always_comb begin
        o_char             = '0;
        o_char.data        = data_q;
        o_char.is_hex      = is_digit | is_alpha;
        o_char.is_cr       = (data_q == `CON_ASCII_CR);
        o_char.is_colon    = (data_q == `CON_ASCII_COLON);
        o_char.is_cmd_load = (data_up == CHR_L);
        o_char.is_cmd_read = (data_up == CHR_R);
        if (is_digit) begin
            o_char.nibble = data_q[3:0];
        end else if (is_alpha) begin
            o_char.nibble = data_q[3:0] + 4'd9;   // 'A' low bits are 1
        end
    end

endmodule

`default_nettype wire

//--- cmd_parser.sv
`default_nettype none

`include "console_params.svh"

module cmd_parser (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_char_strobe,
    input  console_pkg::rx_char_t       i_char,
    input  wire logic                   i_tx_idle,
    output console_pkg::tx_req_t        o_req,
    output logic [`CON_SEED_W-1:0]      o_seed,
    output logic                        o_error
);

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_LOAD_COLON  = 3'd1,
        ST_LOAD_DIGITS = 3'd2,
        ST_READ_COLON  = 3'd3,
        ST_ERROR       = 3'd4
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   dump_pend;  // colon of R: echoed, dump still owed
    logic   dump_go;
    logic   accept;
    logic   echo;
    logic   pend_set;
    logic   seed_clr;
    logic   seed_shift;

    // a char counts only when the sequencer is free and nothing is queued
    assign accept  = i_char_strobe & i_tx_idle & ~o_req.valid & ~dump_pend;
    assign dump_go = dump_pend & i_tx_idle & ~o_req.valid;
    assign o_error = (state == ST_ERROR);

    // ------------------------------
    // next state and actions
    // ------------------------------
    always_comb begin
        state_nxt  = state;
        echo       = 1'b0;
        pend_set   = 1'b0;
        seed_clr   = 1'b0;
        seed_shift = 1'b0;
        if (accept) begin
            case (state)
                ST_IDLE: begin
                    echo = 1'b1;    // everything is echoed here
                    if (i_char.is_cmd_load) begin
                        state_nxt = ST_LOAD_COLON;
                    end else if (i_char.is_cmd_read) begin
                        state_nxt = ST_READ_COLON;
                    end
                end
                ST_LOAD_COLON: begin
                    if (i_char.is_colon) begin
                        echo      = 1'b1;
                        seed_clr  = 1'b1;   // fresh seed for the digits
                        state_nxt = ST_LOAD_DIGITS;
                    end else begin
                        state_nxt = ST_ERROR;
                    end
                end
                ST_READ_COLON: begin
                    if (i_char.is_colon) begin
                        echo      = 1'b1;
                        pend_set  = 1'b1;   // dump follows the colon echo
                        state_nxt = ST_IDLE;
                    end else begin
                        state_nxt = ST_ERROR;
                    end
                end
                ST_LOAD_DIGITS: begin
                    if (i_char.is_hex) begin
                        echo       = 1'b1;
                        seed_shift = 1'b1;
                    end else if (i_char.is_cr) begin
                        echo      = 1'b1;
                        state_nxt = ST_IDLE;
                    end else begin
                        state_nxt = ST_ERROR;
                    end
                end
                default: begin
                    state_nxt = ST_ERROR;   // sticky until reset
                end
            endcase
        end
    end

    // ------------------------------
    // state, seed, requests
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            dump_pend <= 1'b0;
            o_req     <= '0;
            o_seed    <= `CON_SEED_RESET;
        end else begin
            state       <= state_nxt;
            o_req.valid <= 1'b0;
            if (seed_clr) begin
                o_seed <= '0;
            end else if (seed_shift) begin
                o_seed <= {o_seed[`CON_SEED_W-5:0], i_char.nibble}; // in from the right
            end
            if (dump_go) begin
                o_req.valid <= 1'b1;
                o_req.kind  <= console_pkg::REQ_DUMP;
                dump_pend   <= 1'b0;
            end else if (echo) begin
                o_req.valid <= 1'b1;
                o_req.kind  <= console_pkg::REQ_ECHO;
                o_req.data  <= i_char.data;
                dump_pend   <= pend_set;
            end
        end
    end

endmodule

`default_nettype wire

//--- tx_sequencer.sv
`default_nettype none

`include "console_params.svh"

module tx_sequencer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  console_pkg::tx_req_t        i_req,
    input  wire logic [`CON_SEED_W-1:0] i_seed,
    input  wire logic                   i_tx_busy,
    output logic                        o_tx_idle,
    output logic                        o_tx_valid,
    output logic [`CON_BYTE_W-1:0]      o_tx_data
);

    // dump is the digits, then CR at index HEX_DIGITS and LF after it
    localparam logic [3:0] DUMP_LAST = `CON_HEX_DIGITS + 1;

    typedef enum logic [1:0] {
        TX_IDLE    = 2'd0,
        TX_WAIT_HI = 2'd1,  // byte handed over, busy not seen yet
        TX_WAIT_LO = 2'd2   // transmitter working on it
    } tx_state_e;

    tx_state_e              state;
    logic [3:0]             cnt;        // index of the byte last sent
    logic [3:0]             last_idx;
    console_pkg::req_kind_e kind_q;
    logic [`CON_BYTE_W-1:0] data_q;
    logic [`CON_SEED_W-1:0] seed_q;     // frozen copy for the dump
    logic                   first;
    logic                   more;
    logic                   send_now;
    logic [`CON_BYTE_W-1:0] send_byte;

    function automatic logic [`CON_BYTE_W-1:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};     // '0'..'9'
        end
        return 8'h37 + {4'h0, nib};         // 'A'..'F'
    endfunction

    // byte number idx of the reply to one request
    function automatic logic [`CON_BYTE_W-1:0] byte_at(
        input console_pkg::req_kind_e kind,
        input logic [`CON_BYTE_W-1:0] data,
        input logic [`CON_SEED_W-1:0] seed,
        input logic [3:0]             idx
    );
        logic [`CON_SEED_W-1:0] shifted;
        shifted = seed << (4 * idx);        // msb nibble first
        if (kind == console_pkg::REQ_ECHO) begin
            return (idx == 4'd0) ? data : `CON_ASCII_LF;
        end
        if (idx < `CON_HEX_DIGITS) begin
            return hex_char(shifted[`CON_SEED_W-1 -: 4]);
        end
        return (idx == `CON_HEX_DIGITS) ? `CON_ASCII_CR : `CON_ASCII_LF;
    endfunction

    // ------------------------------
    // byte selection
    // ------------------------------
    assign last_idx = (kind_q == console_pkg::REQ_DUMP)    ? DUMP_LAST :
                      (data_q == `CON_ASCII_CR)            ? 4'd1 : 4'd0;

    assign first     = (state == TX_IDLE) & i_req.valid;
    assign more      = (state == TX_WAIT_LO) & ~i_tx_busy & (cnt != last_idx);
    assign send_now  = first | more;
    assign send_byte = first ? byte_at(i_req.kind, i_req.data, i_seed, 4'd0)
                             : byte_at(kind_q, data_q, seed_q, cnt + 4'd1);
    assign o_tx_idle = (state == TX_IDLE);

    // ------------------------------
    // busy handshake
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= TX_IDLE;
            cnt        <= 4'd0;
            o_tx_valid <= 1'b0;
        end else begin
            o_tx_valid <= send_now;     // single-cycle pulse
            case (state)
                TX_IDLE: begin
                    if (i_req.valid) begin
                        cnt   <= 4'd0;
                        state <= TX_WAIT_HI;
                    end
                end
                TX_WAIT_HI: begin
                    if (i_tx_busy) begin
                        state <= TX_WAIT_LO;
                    end
                end
                TX_WAIT_LO: begin
                    if (!i_tx_busy) begin
                        if (cnt == last_idx) begin
                            state <= TX_IDLE;   // reply finished
                        end else begin
                            cnt   <= cnt + 4'd1;
                            state <= TX_WAIT_HI;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (first) begin
            kind_q <= i_req.kind;
            data_q <= i_req.data;
            seed_q <= i_seed;
        end
        if (send_now) begin
            o_tx_data <= send_byte;
        end
    end

endmodule

`default_nettype wire

//--- seed_console.sv
`default_nettype none

`include "console_params.svh"

module seed_console (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_rx_rdy,
    input  wire logic [`CON_BYTE_W-1:0] i_rx_data,
    input  wire logic                   i_tx_busy,
    output logic                        o_tx_valid,
    output logic [`CON_BYTE_W-1:0]      o_tx_data,
    output logic                        o_error
);

    logic                   char_strobe;
    console_pkg::rx_char_t  rx_char;
    console_pkg::tx_req_t   tx_req;
    logic [`CON_SEED_W-1:0] seed;
    logic                   tx_idle;

    // ------------------------------
    // receive, parse, transmit
    // ------------------------------
    uart_rx_capture rx0 (
        .clk           (clk),
        .rst           (rst),
        .i_rx_rdy      (i_rx_rdy),
        .i_rx_data     (i_rx_data),
        .o_char_strobe (char_strobe),
        .o_char        (rx_char)
    );

    cmd_parser parser0 (
        .clk           (clk),
        .rst           (rst),
        .i_char_strobe (char_strobe),
        .i_char        (rx_char),
        .i_tx_idle     (tx_idle),      // chars dropped while a reply runs
        .o_req         (tx_req),
        .o_seed        (seed),
        .o_error       (o_error)
    );

    tx_sequencer tx0 (
        .clk        (clk),
        .rst        (rst),
        .i_req      (tx_req),
        .i_seed     (seed),
        .i_tx_busy  (i_tx_busy),
        .o_tx_idle  (tx_idle),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data)
    );

endmodule

`default_nettype wire

//--- tb_seed_console.sv
`default_nettype none

`include "console_params.svh"

module tb_seed_console;

    localparam int CLK_HALF  = 50;
    localparam int DRV_DLY   = 10;     // input change after the rising edge
    localparam int BUSY_MAX  = 8;
    localparam int NUM_TESTS = 6;
    localparam int SETTLE    = 4;      // quiet cycles after each character
    localparam int CHAR_COST = 16;

    // console model states
    localparam int M_IDLE = 0;
    localparam int M_LCOL = 1;
    localparam int M_LDIG = 2;
    localparam int M_RCOL = 3;
    localparam int M_ERR  = 4;

    logic                   clk;
    logic                   rst;
    logic                   i_rx_rdy;
    logic [`CON_BYTE_W-1:0] i_rx_data;
    logic                   i_tx_busy;
    logic                   o_tx_valid;
    logic [`CON_BYTE_W-1:0] o_tx_data;
    logic                   o_error;

    string tname [NUM_TESTS];
    string tin   [NUM_TESTS];
    string tout  [NUM_TESTS];
    logic  terr  [NUM_TESTS];

    logic [`CON_BYTE_W-1:0] rx_bytes[$];   // bytes seen on the tx side
    logic [15:0]            lfsr;
    logic                   tx_active;     // transmitter model mid-byte
    int                     model_state;
    int                     cycles = 0;
    int                     cycle_limit = 0;
    int                     err_count;
    int                     pass_count;
    int                     fail_count;

    seed_console dut0 (
        .clk        (clk),
        .rst        (rst),
        .i_rx_rdy   (i_rx_rdy),
        .i_rx_data  (i_rx_data),
        .i_tx_busy  (i_tx_busy),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data),
        .o_error    (o_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;   // galois taps 16,14,13,11
        end
        return n;
    endfunction

    // three lfsr bits give 1..8 cycles of busy
    task automatic take_busy_len(output int len);
        logic [2:0] bits;
        bits = 3'd0;
        for (int i = 0; i < 3; i++) begin
            bits = {bits[1:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        len = int'(bits) + 1;
    endtask

    function automatic bit is_hex_char(input byte c);
        return (c >= "0" && c <= "9") || (c >= "A" && c <= "F") || (c >= "a" && c <= "f");
    endfunction

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // number of bytes the console owes for one received character
    task automatic expect_reply(input byte c, output int n);
        n = 0;
        case (model_state)
            M_IDLE: begin
                n = (c == `CON_ASCII_CR) ? 2 : 1;
                if (c == "L" || c == "l") begin
                    model_state = M_LCOL;
                end else if (c == "R" || c == "r") begin
                    model_state = M_RCOL;
                end
            end
            M_LCOL: begin
                n = (c == ":") ? 1 : 0;
                model_state = (c == ":") ? M_LDIG : M_ERR;
            end
            M_RCOL: begin
                n = (c == ":") ? 1 + `CON_HEX_DIGITS + 2 : 0;   // colon, digits, CR LF
                model_state = (c == ":") ? M_IDLE : M_ERR;
            end
            M_LDIG: begin
                if (is_hex_char(c)) begin
                    n = 1;
                end else if (c == `CON_ASCII_CR) begin
                    n = 2;
                    model_state = M_IDLE;
                end else begin
                    model_state = M_ERR;
                end
            end
            default: n = 0;
        endcase
    endtask

    task automatic load_table();
        tname[0] = "plain echo";
        tin[0]   = "x7\015";
        tout[0]  = "x7\015\012";
        terr[0]  = 1'b0;
        tname[1] = "load and read";
        tin[1]   = "L:1234ABCD\015R:";
        tout[1]  = "L:1234ABCD\015\012R:1234ABCD\015\012";
        terr[1]  = 1'b0;
        tname[2] = "lower case, ten digits";
        tin[2]   = "l:9a8b7c6d5e\015r:";
        tout[2]  = "l:9a8b7c6d5e\015\012r:8B7C6D5E\015\012";
        terr[2]  = 1'b0;
        tname[3] = "empty load";
        tin[3]   = "L:\015R:";
        tout[3]  = "L:\015\012R:00000000\015\012";
        terr[3]  = 1'b0;
        tname[4] = "back to back dumps";
        tin[4]   = "L:FFFFFFFF\015R:R:";
        tout[4]  = "L:FFFFFFFF\015\012R:FFFFFFFF\015\012R:FFFFFFFF\015\012";
        terr[4]  = 1'b0;
        tname[5] = "bad colon, sticky error";   // must stay last
        tin[5]   = "LQR:";
        tout[5]  = "L";
        terr[5]  = 1'b1;
    endtask

    // ------------------------------
    // transmitter model and monitor
    // ------------------------------
    initial begin
        int len;
        i_tx_busy = 1'b0;
        tx_active = 1'b0;
        lfsr      = 16'd12;
        forever begin
            @(negedge clk);
            if (o_tx_valid === 1'b1) begin
                tx_active = 1'b1;
                take_busy_len(len);
                @(posedge clk);
                #DRV_DLY i_tx_busy = 1'b1;
                repeat (len) @(posedge clk);
                #DRV_DLY i_tx_busy = 1'b0;
                tx_active = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (o_tx_valid === 1'b1) begin
            rx_bytes.push_back(o_tx_data);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: replies still missing after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    // ready high for two cycles, then wait for the reply and its busy phase
    task automatic send_char(input byte c, input int want);
        @(posedge clk);
        #DRV_DLY;
        i_rx_data = c;
        i_rx_rdy  = 1'b1;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        i_rx_rdy = 1'b0;
        while (rx_bytes.size() < want || tx_active) begin
            @(posedge clk);
        end
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic run_test(input int t);
        int want;
        int n;
        int errs_before;
        errs_before = err_count;
        want = 0;
        rx_bytes.delete();
        for (int i = 0; i < tin[t].len(); i++) begin
            expect_reply(tin[t][i], n);
            want = want + n;
            send_char(tin[t][i], want);
        end
        @(negedge clk);
        compare_values("o_tx_valid count", rx_bytes.size(), tout[t].len());
        for (int i = 0; i < tout[t].len() && i < rx_bytes.size(); i++) begin
            compare_values($sformatf("o_tx_data[%0d]", i), 32'(rx_bytes[i]),
                           32'(tout[t][i]));
        end
        compare_values("o_error", 32'(o_error), 32'(terr[t]));
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %0d (%s): passed", t, tname[t]);
        end else begin
            fail_count++;
            $display("test %0d (%s): failed", t, tname[t]);
        end
    endtask

    initial begin
        int total;
        rst         = 1'b1;
        i_rx_rdy    = 1'b0;
        i_rx_data   = '0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        model_state = M_IDLE;
        load_table();
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += tout[t].len() * (BUSY_MAX + 6) + tin[t].len() * CHAR_COST;
        end
        cycle_limit = total + 200;
        repeat (4) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        @(negedge clk);
        compare_values("o_tx_valid", 32'(o_tx_valid), 32'h0);   // idle out of reset
        compare_values("o_error", 32'(o_error), 32'h0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 NUM_TESTS, pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
console_pkg.sv
uart_rx_capture.sv
cmd_parser.sv
tx_sequencer.sv
seed_console.sv
tb_seed_console.sv

//--- Makefile
# Verilator build and run for the seed console testbench

VERILATOR ?= verilator
TOP       ?= tb_seed_console
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard *.sv *.svh)
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
